// ==== design/rv_isa_pkg.sv ====
package rv_isa_pkg;

  // ==============================
  // instruction fields
  // ==============================
  typedef logic [6:0] opcode_t;
  typedef logic [2:0] funct3_t;

  localparam opcode_t OPC_OP     = 7'b0110011;
  localparam opcode_t OPC_OP_IMM = 7'b0010011;
  localparam opcode_t OPC_LUI    = 7'b0110111;
  localparam opcode_t OPC_AUIPC  = 7'b0010111;
  localparam opcode_t OPC_LOAD   = 7'b0000011;
  localparam opcode_t OPC_STORE  = 7'b0100011;
  localparam opcode_t OPC_BRANCH = 7'b1100011;
  localparam opcode_t OPC_JAL    = 7'b1101111;
  localparam opcode_t OPC_JALR   = 7'b1100111;

  // alu funct3, shared by OP and OP-IMM
  localparam funct3_t F3_ADD  = 3'b000;
  localparam funct3_t F3_SLL  = 3'b001;
  localparam funct3_t F3_SLT  = 3'b010;
  localparam funct3_t F3_SLTU = 3'b011;
  localparam funct3_t F3_XOR  = 3'b100;
  localparam funct3_t F3_SR   = 3'b101;
  localparam funct3_t F3_OR   = 3'b110;
  localparam funct3_t F3_AND  = 3'b111;
  // beq is the only other branch kept
  localparam funct3_t F3_BNE  = 3'b001;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT,
    ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA, ALU_PASS_B
  } alu_op_t;

  // addi x0, x0, 0
  localparam logic [31:0] NOP_INSTR = 32'h0000_0013;

endpackage

// ==== design/rv_core_pkg.sv ====
package rv_core_pkg;

  // ==============================
  // datapath types
  // ==============================
  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_addr_t;

  // writeback source, chosen in decode
  typedef enum logic [1:0] {
    WB_ALU,
    WB_PC4,
    WB_MEM
  } wb_sel_t;

  // operand source for the execute stage
  typedef enum logic [1:0] {
    FWD_NONE,
    FWD_MEM,
    FWD_WB
  } fwd_sel_t;

endpackage

// ==== design/fetch_stage.sv ====
`timescale 1ns/10ps

module fetch_stage #(
  parameter rv_core_pkg::word_t RESET_PC = '0
) (
  input  logic               clk,
  input  logic               arst_n_i,
  input  logic               stall_i,
  input  logic               flush_i,
  input  logic               pc_sel_i,
  input  rv_core_pkg::word_t jump_target_i,
  input  rv_core_pkg::word_t imem_data_i,
  output rv_core_pkg::word_t imem_addr_o,
  output rv_core_pkg::word_t pc_id_o,
  output rv_core_pkg::word_t instr_id_o
);
  import rv_core_pkg::*;
  import rv_isa_pkg::*;

  word_t pc_q;
  word_t pc_next;

  // redirect from the memory stage wins over sequential fetch
  assign pc_next     = pc_sel_i ? jump_target_i : pc_q + 32'd4;
  assign imem_addr_o = pc_q;

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pc_q <= RESET_PC;
    end else if (!stall_i) begin
      pc_q <= pc_next;
    end
  end

  // ==============================
  // IF/ID register
  // ==============================
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      instr_id_o <= NOP_INSTR;
    end else if (flush_i) begin
      instr_id_o <= NOP_INSTR;
    end else if (!stall_i) begin
      instr_id_o <= imem_data_i;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall_i) begin
      pc_id_o <= pc_q;
    end
  end

endmodule

// ==== design/reg_file.sv ====
`timescale 1ns/10ps

module reg_file (
  input  logic                   clk,
  input  logic                   arst_n_i,
  input  logic                   we_i,
  input  rv_core_pkg::reg_addr_t waddr_i,
  input  rv_core_pkg::word_t     wdata_i,
  input  rv_core_pkg::reg_addr_t raddr1_i,
  input  rv_core_pkg::reg_addr_t raddr2_i,
  output rv_core_pkg::word_t     rdata1_o,
  output rv_core_pkg::word_t     rdata2_o
);

  // x1..x31, x0 has no storage
  rv_core_pkg::word_t regs_q [1:31];

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 1; i < 32; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  assign rdata1_o = (raddr1_i == '0) ? '0 : regs_q[raddr1_i];
  assign rdata2_o = (raddr2_i == '0) ? '0 : regs_q[raddr2_i];

endmodule

// ==== design/decode_stage.sv ====
`timescale 1ns/10ps

module decode_stage (
  input  logic                   clk,
  input  logic                   arst_n_i,
  input  logic                   stall_i,
  input  logic                   flush_i,
  input  rv_core_pkg::word_t     pc_id_i,
  input  rv_core_pkg::word_t     instr_id_i,
  input  logic                   wb_we_i,
  input  rv_core_pkg::reg_addr_t wb_rd_i,
  input  rv_core_pkg::word_t     wb_data_i,
  input  logic                   fwd_rs1_id_i,
  input  logic                   fwd_rs2_id_i,
  output rv_core_pkg::reg_addr_t rs1_id_o,
  output rv_core_pkg::reg_addr_t rs2_id_o,
  output rv_core_pkg::word_t     pc_exe_o,
  output rv_core_pkg::reg_addr_t rs1_exe_o,
  output rv_core_pkg::reg_addr_t rs2_exe_o,
  output rv_core_pkg::reg_addr_t rd_exe_o,
  output rv_core_pkg::word_t     rdata1_exe_o,
  output rv_core_pkg::word_t     rdata2_exe_o,
  output rv_core_pkg::word_t     imm_exe_o,
  output rv_isa_pkg::alu_op_t    alu_op_exe_o,
  output logic                   alu_src_imm_exe_o,
  output logic                   op1_pc_exe_o,
  output logic                   reg_write_exe_o,
  output logic                   mem_write_exe_o,
  output logic                   is_load_exe_o,
  output logic                   branch_exe_o,
  output logic                   branch_ne_exe_o,
  output logic                   jump_exe_o,
  output logic                   jalr_exe_o,
  output rv_core_pkg::wb_sel_t   wb_sel_exe_o
);
  import rv_core_pkg::*;
  import rv_isa_pkg::*;

  opcode_t   opcode;
  funct3_t   funct3;
  reg_addr_t rd;
  word_t     rf_rdata1;
  word_t     rf_rdata2;
  word_t     imm;
  alu_op_t   alu_op;
  wb_sel_t   wb_sel;
  logic      reg_write, mem_write, is_load, branch, branch_ne;
  logic      jump, jalr, alu_src_imm, op1_pc;

  // funct7[5] picks sub and sra, sub only for register form
  function automatic alu_op_t alu_decode(input funct3_t f3, input logic f7_5,
                                         input logic is_reg);
    alu_op_t op;
    case (f3)
      F3_ADD:  op = (is_reg && f7_5) ? ALU_SUB : ALU_ADD;
      F3_SLL:  op = ALU_SLL;
      F3_SLT:  op = ALU_SLT;
      F3_SLTU: op = ALU_SLTU;
      F3_XOR:  op = ALU_XOR;
      F3_SR:   op = f7_5 ? ALU_SRA : ALU_SRL;
      F3_OR:   op = ALU_OR;
      F3_AND:  op = ALU_AND;
      default: op = ALU_ADD;
    endcase
    return op;
  endfunction

  assign opcode   = instr_id_i[6:0];
  assign funct3   = instr_id_i[14:12];
  assign rd       = instr_id_i[11:7];
  assign rs1_id_o = instr_id_i[19:15];
  assign rs2_id_o = instr_id_i[24:20];

  reg_file reg_file_inst (
    .clk      (clk),
    .arst_n_i (arst_n_i),
    .we_i     (wb_we_i),
    .waddr_i  (wb_rd_i),
    .wdata_i  (wb_data_i),
    .raddr1_i (rs1_id_o),
    .raddr2_i (rs2_id_o),
    .rdata1_o (rf_rdata1),
    .rdata2_o (rf_rdata2)
  );

  // ==============================
  // control and immediates
  // ==============================
  always_comb begin
    reg_write   = 1'b0;
    mem_write   = 1'b0;
    is_load     = 1'b0;
    branch      = 1'b0;
    branch_ne   = 1'b0;
    jump        = 1'b0;
    jalr        = 1'b0;
    alu_src_imm = 1'b0;
    op1_pc      = 1'b0;
    alu_op      = ALU_ADD;
    wb_sel      = WB_ALU;
    imm         = '0;
    case (opcode)
      OPC_OP: begin
        reg_write = 1'b1;
        alu_op    = alu_decode(funct3, instr_id_i[30], 1'b1);
      end
      OPC_OP_IMM: begin
        reg_write   = 1'b1;
        alu_src_imm = 1'b1;
        alu_op      = alu_decode(funct3, instr_id_i[30], 1'b0);
        imm         = {{20{instr_id_i[31]}}, instr_id_i[31:20]};
      end
      OPC_LUI: begin
        reg_write   = 1'b1;
        alu_src_imm = 1'b1;
        alu_op      = ALU_PASS_B;
        imm         = {instr_id_i[31:12], 12'b0};
      end
      OPC_AUIPC: begin
        reg_write   = 1'b1;
        alu_src_imm = 1'b1;
        op1_pc      = 1'b1;
        imm         = {instr_id_i[31:12], 12'b0};
      end
      OPC_LOAD: begin
        reg_write   = 1'b1;
        alu_src_imm = 1'b1;
        is_load     = 1'b1;
        wb_sel      = WB_MEM;
        imm         = {{20{instr_id_i[31]}}, instr_id_i[31:20]};
      end
      OPC_STORE: begin
        mem_write   = 1'b1;
        alu_src_imm = 1'b1;
        imm         = {{20{instr_id_i[31]}}, instr_id_i[31:25], instr_id_i[11:7]};
      end
      OPC_BRANCH: begin
        branch    = 1'b1;
        branch_ne = (funct3 == F3_BNE);
        imm       = {{19{instr_id_i[31]}}, instr_id_i[31], instr_id_i[7],
                     instr_id_i[30:25], instr_id_i[11:8], 1'b0};
      end
      OPC_JAL: begin
        reg_write = 1'b1;
        jump      = 1'b1;
        wb_sel    = WB_PC4;
        imm       = {{11{instr_id_i[31]}}, instr_id_i[31], instr_id_i[19:12],
                     instr_id_i[20], instr_id_i[30:21], 1'b0};
      end
      OPC_JALR: begin
        reg_write = 1'b1;
        jump      = 1'b1;
        jalr      = 1'b1;
        wb_sel    = WB_PC4;
        imm       = {{20{instr_id_i[31]}}, instr_id_i[31:20]};
      end
      default: begin
        reg_write = 1'b0;
      end
    endcase
    // writes to x0 are dropped here and nowhere else
    if (rd == '0) begin
      reg_write = 1'b0;
    end
  end

  // ==============================
  // ID/EXE register
  // ==============================
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i || stall_i || flush_i) begin
      alu_op_exe_o      <= ALU_ADD;
      alu_src_imm_exe_o <= 1'b0;
      op1_pc_exe_o      <= 1'b0;
      reg_write_exe_o   <= 1'b0;
      mem_write_exe_o   <= 1'b0;
      is_load_exe_o     <= 1'b0;
      branch_exe_o      <= 1'b0;
      branch_ne_exe_o   <= 1'b0;
      jump_exe_o        <= 1'b0;
      jalr_exe_o        <= 1'b0;
      wb_sel_exe_o      <= WB_ALU;
    end else begin
      alu_op_exe_o      <= alu_op;
      alu_src_imm_exe_o <= alu_src_imm;
      op1_pc_exe_o      <= op1_pc;
      reg_write_exe_o   <= reg_write;
      mem_write_exe_o   <= mem_write;
      is_load_exe_o     <= is_load;
      branch_exe_o      <= branch;
      branch_ne_exe_o   <= branch_ne;
      jump_exe_o        <= jump;
      jalr_exe_o        <= jalr;
      wb_sel_exe_o      <= wb_sel;
    end
  end

  // operands take the value being written back this cycle
  always_ff @(posedge clk) begin
    pc_exe_o     <= pc_id_i;
    rs1_exe_o    <= rs1_id_o;
    rs2_exe_o    <= rs2_id_o;
    rd_exe_o     <= rd;
    imm_exe_o    <= imm;
    rdata1_exe_o <= fwd_rs1_id_i ? wb_data_i : rf_rdata1;
    rdata2_exe_o <= fwd_rs2_id_i ? wb_data_i : rf_rdata2;
  end

endmodule

// ==== design/hazard_unit.sv ====
`timescale 1ns/10ps

module hazard_unit (
  input  rv_core_pkg::reg_addr_t rs1_id_i,
  input  rv_core_pkg::reg_addr_t rs2_id_i,
  input  rv_core_pkg::reg_addr_t rs1_exe_i,
  input  rv_core_pkg::reg_addr_t rs2_exe_i,
  input  rv_core_pkg::reg_addr_t rd_exe_i,
  input  logic                   is_load_exe_i,
  input  rv_core_pkg::reg_addr_t rd_mem_i,
  input  logic                   reg_write_mem_i,
  input  rv_core_pkg::reg_addr_t rd_wb_i,
  input  logic                   reg_write_wb_i,
  input  logic                   pc_sel_i,
  output logic                   fwd_rs1_id_o,
  output logic                   fwd_rs2_id_o,
  output rv_core_pkg::fwd_sel_t  fwd_rs1_exe_o,
  output rv_core_pkg::fwd_sel_t  fwd_rs2_exe_o,
  output logic                   stall_o,
  output logic                   flush_o
);
  import rv_core_pkg::*;

  // the newer result in memory wins over writeback
  function automatic fwd_sel_t exe_fwd(input reg_addr_t rs, input logic we_mem,
                                       input reg_addr_t rd_mem, input logic we_wb,
                                       input reg_addr_t rd_wb);
    fwd_sel_t sel;
    if (we_mem && (rd_mem == rs)) begin
      sel = FWD_MEM;
    end else if (we_wb && (rd_wb == rs)) begin
      sel = FWD_WB;
    end else begin
      sel = FWD_NONE;
    end
    return sel;
  endfunction

  assign fwd_rs1_exe_o = exe_fwd(rs1_exe_i, reg_write_mem_i, rd_mem_i,
                                 reg_write_wb_i, rd_wb_i);
  assign fwd_rs2_exe_o = exe_fwd(rs2_exe_i, reg_write_mem_i, rd_mem_i,
                                 reg_write_wb_i, rd_wb_i);

  // register file is written at the same edge decode samples it
  assign fwd_rs1_id_o = reg_write_wb_i && (rd_wb_i == rs1_id_i);
  assign fwd_rs2_id_o = reg_write_wb_i && (rd_wb_i == rs2_id_i);

  // no load-use stall when the pair is on the wrong path
  assign stall_o = is_load_exe_i && !pc_sel_i &&
                   ((rd_exe_i == rs1_id_i) || (rd_exe_i == rs2_id_i));
  assign flush_o = pc_sel_i;

endmodule

// ==== design/execute_stage.sv ====
`timescale 1ns/10ps

module execute_stage (
  input  logic                   clk,
  input  logic                   arst_n_i,
  input  logic                   flush_i,
  input  rv_core_pkg::word_t     pc_exe_i,
  input  rv_core_pkg::reg_addr_t rd_exe_i,
  input  rv_core_pkg::word_t     rdata1_exe_i,
  input  rv_core_pkg::word_t     rdata2_exe_i,
  input  rv_core_pkg::word_t     imm_exe_i,
  input  rv_isa_pkg::alu_op_t    alu_op_exe_i,
  input  logic                   alu_src_imm_exe_i,
  input  logic                   op1_pc_exe_i,
  input  logic                   reg_write_exe_i,
  input  logic                   mem_write_exe_i,
  input  logic                   is_load_exe_i,
  input  logic                   branch_exe_i,
  input  logic                   branch_ne_exe_i,
  input  logic                   jump_exe_i,
  input  logic                   jalr_exe_i,
  input  rv_core_pkg::wb_sel_t   wb_sel_exe_i,
  input  rv_core_pkg::fwd_sel_t  fwd_rs1_i,
  input  rv_core_pkg::fwd_sel_t  fwd_rs2_i,
  input  rv_core_pkg::word_t     mem_result_i,
  input  rv_core_pkg::word_t     wb_data_i,
  output rv_core_pkg::word_t     alu_result_mem_o,
  output rv_core_pkg::word_t     store_data_mem_o,
  output rv_core_pkg::word_t     pc4_mem_o,
  output rv_core_pkg::word_t     jump_target_mem_o,
  output rv_core_pkg::reg_addr_t rd_mem_o,
  output logic                   reg_write_mem_o,
  output logic                   mem_write_mem_o,
  output logic                   is_load_mem_o,
  output logic                   take_mem_o,
  output rv_core_pkg::wb_sel_t   wb_sel_mem_o
);
  import rv_core_pkg::*;
  import rv_isa_pkg::*;

  word_t rs1_val, rs2_val;
  word_t op1, op2;
  word_t alu_result;
  word_t jump_target;
  logic  take;

  function automatic word_t fwd_mux(input fwd_sel_t sel, input word_t reg_val,
                                    input word_t mem_val, input word_t wb_val);
    word_t val;
    case (sel)
      FWD_MEM: val = mem_val;
      FWD_WB:  val = wb_val;
      default: val = reg_val;
    endcase
    return val;
  endfunction

  assign rs1_val = fwd_mux(fwd_rs1_i, rdata1_exe_i, mem_result_i, wb_data_i);
  assign rs2_val = fwd_mux(fwd_rs2_i, rdata2_exe_i, mem_result_i, wb_data_i);
  assign op1     = op1_pc_exe_i ? pc_exe_i : rs1_val;
  assign op2     = alu_src_imm_exe_i ? imm_exe_i : rs2_val;

  // ==============================
  // ALU
  // ==============================
  always_comb begin
    case (alu_op_exe_i)
      ALU_ADD:    alu_result = op1 + op2;
      ALU_SUB:    alu_result = op1 - op2;
      ALU_AND:    alu_result = op1 & op2;
      ALU_OR:     alu_result = op1 | op2;
      ALU_XOR:    alu_result = op1 ^ op2;
      ALU_SLT:    alu_result = {31'b0, $signed(op1) < $signed(op2)};
      ALU_SLTU:   alu_result = {31'b0, op1 < op2};
      ALU_SLL:    alu_result = op1 << op2[4:0];
      ALU_SRL:    alu_result = op1 >> op2[4:0];
      ALU_SRA:    alu_result = $signed(op1) >>> op2[4:0];
      ALU_PASS_B: alu_result = op2;
      default:    alu_result = '0;
    endcase
  end

  // jalr drops bit 0 of the sum
  assign jump_target = jalr_exe_i ? ((rs1_val + imm_exe_i) & ~32'd1)
                                  : pc_exe_i + imm_exe_i;
  assign take = jump_exe_i |
                (branch_exe_i & ((rs1_val == rs2_val) ^ branch_ne_exe_i));

  // ==============================
  // EXE/MEM register
  // ==============================
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i || flush_i) begin
      reg_write_mem_o <= 1'b0;
      mem_write_mem_o <= 1'b0;
      is_load_mem_o   <= 1'b0;
      take_mem_o      <= 1'b0;
      wb_sel_mem_o    <= WB_ALU;
    end else begin
      reg_write_mem_o <= reg_write_exe_i;
      mem_write_mem_o <= mem_write_exe_i;
      is_load_mem_o   <= is_load_exe_i;
      take_mem_o      <= take;
      wb_sel_mem_o    <= wb_sel_exe_i;
    end
  end

  always_ff @(posedge clk) begin
    alu_result_mem_o  <= alu_result;
    store_data_mem_o  <= rs2_val;
    pc4_mem_o         <= pc_exe_i + 32'd4;
    jump_target_mem_o <= jump_target;
    rd_mem_o          <= rd_exe_i;
  end

endmodule

// ==== design/mem_wb_stage.sv ====
`timescale 1ns/10ps

module mem_wb_stage (
  input  logic                   clk,
  input  logic                   arst_n_i,
  input  rv_core_pkg::word_t     alu_result_mem_i,
  input  rv_core_pkg::word_t     store_data_mem_i,
  input  rv_core_pkg::word_t     pc4_mem_i,
  input  rv_core_pkg::word_t     jump_target_mem_i,
  input  rv_core_pkg::reg_addr_t rd_mem_i,
  input  logic                   reg_write_mem_i,
  input  logic                   mem_write_mem_i,
  input  logic                   is_load_mem_i,
  input  logic                   take_mem_i,
  input  rv_core_pkg::wb_sel_t   wb_sel_mem_i,
  input  rv_core_pkg::word_t     dmem_rdata_i,
  output rv_core_pkg::word_t     dmem_addr_o,
  output rv_core_pkg::word_t     dmem_wdata_o,
  output logic                   dmem_we_o,
  output logic                   pc_sel_o,
  output rv_core_pkg::word_t     jump_target_o,
  output rv_core_pkg::word_t     mem_result_o,
  output logic                   wb_we_o,
  output rv_core_pkg::reg_addr_t wb_rd_o,
  output rv_core_pkg::word_t     wb_data_o
);
  import rv_core_pkg::*;

  logic  is_load_wb;
  word_t result_wb;

  assign dmem_addr_o   = alu_result_mem_i;
  assign dmem_wdata_o  = store_data_mem_i;
  assign dmem_we_o     = mem_write_mem_i;
  assign pc_sel_o      = take_mem_i;
  assign jump_target_o = jump_target_mem_i;

  // non-load result, also forwarded back into execute
  assign mem_result_o = (wb_sel_mem_i == WB_PC4) ? pc4_mem_i : alu_result_mem_i;

  // ==============================
  // MEM/WB register
  // ==============================
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wb_we_o    <= 1'b0;
      is_load_wb <= 1'b0;
    end else begin
      wb_we_o    <= reg_write_mem_i;
      is_load_wb <= is_load_mem_i;
    end
  end

  always_ff @(posedge clk) begin
    wb_rd_o   <= rd_mem_i;
    result_wb <= mem_result_o;
  end

  // load data arrives one cycle after the address
  assign wb_data_o = is_load_wb ? dmem_rdata_i : result_wb;

endmodule

// ==== design/core_top.sv ====
`timescale 1ns/10ps

module core_top #(
  parameter rv_core_pkg::word_t RESET_PC = '0
) (
  input  logic                   clk,
  input  logic                   arst_n_i,
  output rv_core_pkg::word_t     imem_addr_o,
  input  rv_core_pkg::word_t     imem_data_i,
  output rv_core_pkg::word_t     dmem_addr_o,
  output rv_core_pkg::word_t     dmem_wdata_o,
  output logic                   dmem_we_o,
  input  rv_core_pkg::word_t     dmem_rdata_i,
  output logic                   wb_we_o,
  output rv_core_pkg::reg_addr_t wb_rd_o,
  output rv_core_pkg::word_t     wb_data_o
);
  import rv_core_pkg::*;
  import rv_isa_pkg::*;

  // hazard control
  logic      stall, flush, pc_sel;
  logic      fwd_rs1_id, fwd_rs2_id;
  fwd_sel_t  fwd_rs1_exe, fwd_rs2_exe;
  // fetch to decode
  word_t     pc_id, instr_id, jump_target;
  reg_addr_t rs1_id, rs2_id;
  // decode to execute
  word_t     pc_exe, rdata1_exe, rdata2_exe, imm_exe;
  reg_addr_t rs1_exe, rs2_exe, rd_exe;
  alu_op_t   alu_op_exe;
  wb_sel_t   wb_sel_exe;
  logic      alu_src_imm_exe, op1_pc_exe, reg_write_exe, mem_write_exe;
  logic      is_load_exe, branch_exe, branch_ne_exe, jump_exe, jalr_exe;
  // execute to memory
  word_t     alu_result_mem, store_data_mem, pc4_mem, jump_target_mem, mem_result;
  reg_addr_t rd_mem;
  wb_sel_t   wb_sel_mem;
  logic      reg_write_mem, mem_write_mem, is_load_mem, take_mem;

  fetch_stage #(
    .RESET_PC (RESET_PC)
  ) fetch_stage_inst (
    .clk           (clk),
    .arst_n_i      (arst_n_i),
    .stall_i       (stall),
    .flush_i       (flush),
    .pc_sel_i      (pc_sel),
    .jump_target_i (jump_target),
    .imem_data_i   (imem_data_i),
    .imem_addr_o   (imem_addr_o),
    .pc_id_o       (pc_id),
    .instr_id_o    (instr_id)
  );

  decode_stage decode_stage_inst (
    .clk               (clk),
    .arst_n_i          (arst_n_i),
    .stall_i           (stall),
    .flush_i           (flush),
    .pc_id_i           (pc_id),
    .instr_id_i        (instr_id),
    .wb_we_i           (wb_we_o),
    .wb_rd_i           (wb_rd_o),
    .wb_data_i         (wb_data_o),
    .fwd_rs1_id_i      (fwd_rs1_id),
    .fwd_rs2_id_i      (fwd_rs2_id),
    .rs1_id_o          (rs1_id),
    .rs2_id_o          (rs2_id),
    .pc_exe_o          (pc_exe),
    .rs1_exe_o         (rs1_exe),
    .rs2_exe_o         (rs2_exe),
    .rd_exe_o          (rd_exe),
    .rdata1_exe_o      (rdata1_exe),
    .rdata2_exe_o      (rdata2_exe),
    .imm_exe_o         (imm_exe),
    .alu_op_exe_o      (alu_op_exe),
    .alu_src_imm_exe_o (alu_src_imm_exe),
    .op1_pc_exe_o      (op1_pc_exe),
    .reg_write_exe_o   (reg_write_exe),
    .mem_write_exe_o   (mem_write_exe),
    .is_load_exe_o     (is_load_exe),
    .branch_exe_o      (branch_exe),
    .branch_ne_exe_o   (branch_ne_exe),
    .jump_exe_o        (jump_exe),
    .jalr_exe_o        (jalr_exe),
    .wb_sel_exe_o      (wb_sel_exe)
  );

  hazard_unit hazard_unit_inst (
    .rs1_id_i        (rs1_id),
    .rs2_id_i        (rs2_id),
    .rs1_exe_i       (rs1_exe),
    .rs2_exe_i       (rs2_exe),
    .rd_exe_i        (rd_exe),
    .is_load_exe_i   (is_load_exe),
    .rd_mem_i        (rd_mem),
    .reg_write_mem_i (reg_write_mem),
    .rd_wb_i         (wb_rd_o),
    .reg_write_wb_i  (wb_we_o),
    .pc_sel_i        (pc_sel),
    .fwd_rs1_id_o    (fwd_rs1_id),
    .fwd_rs2_id_o    (fwd_rs2_id),
    .fwd_rs1_exe_o   (fwd_rs1_exe),
    .fwd_rs2_exe_o   (fwd_rs2_exe),
    .stall_o         (stall),
    .flush_o         (flush)
  );

  execute_stage execute_stage_inst (
    .clk               (clk),
    .arst_n_i          (arst_n_i),
    .flush_i           (flush),
    .pc_exe_i          (pc_exe),
    .rd_exe_i          (rd_exe),
    .rdata1_exe_i      (rdata1_exe),
    .rdata2_exe_i      (rdata2_exe),
    .imm_exe_i         (imm_exe),
    .alu_op_exe_i      (alu_op_exe),
    .alu_src_imm_exe_i (alu_src_imm_exe),
    .op1_pc_exe_i      (op1_pc_exe),
    .reg_write_exe_i   (reg_write_exe),
    .mem_write_exe_i   (mem_write_exe),
    .is_load_exe_i     (is_load_exe),
    .branch_exe_i      (branch_exe),
    .branch_ne_exe_i   (branch_ne_exe),
    .jump_exe_i        (jump_exe),
    .jalr_exe_i        (jalr_exe),
    .wb_sel_exe_i      (wb_sel_exe),
    .fwd_rs1_i         (fwd_rs1_exe),
    .fwd_rs2_i         (fwd_rs2_exe),
    .mem_result_i      (mem_result),
    .wb_data_i         (wb_data_o),
    .alu_result_mem_o  (alu_result_mem),
    .store_data_mem_o  (store_data_mem),
    .pc4_mem_o         (pc4_mem),
    .jump_target_mem_o (jump_target_mem),
    .rd_mem_o          (rd_mem),
    .reg_write_mem_o   (reg_write_mem),
    .mem_write_mem_o   (mem_write_mem),
    .is_load_mem_o     (is_load_mem),
    .take_mem_o        (take_mem),
    .wb_sel_mem_o      (wb_sel_mem)
  );

  mem_wb_stage mem_wb_stage_inst (
    .clk               (clk),
    .arst_n_i          (arst_n_i),
    .alu_result_mem_i  (alu_result_mem),
    .store_data_mem_i  (store_data_mem),
    .pc4_mem_i         (pc4_mem),
    .jump_target_mem_i (jump_target_mem),
    .rd_mem_i          (rd_mem),
    .reg_write_mem_i   (reg_write_mem),
    .mem_write_mem_i   (mem_write_mem),
    .is_load_mem_i     (is_load_mem),
    .take_mem_i        (take_mem),
    .wb_sel_mem_i      (wb_sel_mem),
    .dmem_rdata_i      (dmem_rdata_i),
    .dmem_addr_o       (dmem_addr_o),
    .dmem_wdata_o      (dmem_wdata_o),
    .dmem_we_o         (dmem_we_o),
    .pc_sel_o          (pc_sel),
    .jump_target_o     (jump_target),
    .mem_result_o      (mem_result),
    .wb_we_o           (wb_we_o),
    .wb_rd_o           (wb_rd_o),
    .wb_data_o         (wb_data_o)
  );

endmodule

// ==== test/core_tb.sv ====
`timescale 1ns/10ps

module core_tb;
  import rv_core_pkg::*;

  localparam word_t RESET_PC  = 32'h0000_0000;
  localparam int    MEM_WORDS = 256;

  logic      clk;
  logic      arst_n;
  word_t     imem_addr;
  word_t     imem_data;
  word_t     dmem_addr;
  word_t     dmem_wdata;
  logic      dmem_we;
  word_t     dmem_rdata;
  logic      wb_we;
  reg_addr_t wb_rd;
  word_t     wb_data;

  word_t     imem [0:MEM_WORDS-1];
  word_t     dmem [0:MEM_WORDS-1];

  // expected results in program order
  reg_addr_t exp_rd [$];
  word_t     exp_val [$];
  word_t     exp_addr [$];
  word_t     exp_data [$];

  int   i_count = 0;
  int   w_count = 0;
  int   m_count = 0;
  int   w_seen = 0;
  int   m_seen = 0;
  int   cycle = 0;
  int   error_count = 0;
  int   mismatch_count = 0;
  logic trace_loaded = 1'b0;

  core_top #(
    .RESET_PC (RESET_PC)
  ) core_top_inst (
    .clk          (clk),
    .arst_n_i     (arst_n),
    .imem_addr_o  (imem_addr),
    .imem_data_i  (imem_data),
    .dmem_addr_o  (dmem_addr),
    .dmem_wdata_o (dmem_wdata),
    .dmem_we_o    (dmem_we),
    .dmem_rdata_i (dmem_rdata),
    .wb_we_o      (wb_we),
    .wb_rd_o      (wb_rd),
    .wb_data_o    (wb_data)
  );

  // ==============================
  // clock, reset and memories
  // ==============================
  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    arst_n = 1'b0;
    repeat (8) @(posedge clk);
    arst_n <= 1'b1;
  end

  // instruction memory answers in the same cycle
  assign imem_data = imem[imem_addr[9:2]];

  // data memory returns read data one cycle after the address
  always @(posedge clk) begin
    if (dmem_we === 1'b1) begin
      dmem[dmem_addr[9:2]] <= dmem_wdata;
    end
    dmem_rdata <= dmem[dmem_addr[9:2]];
  end

  // ==============================
  // trace reader
  // ==============================
  task automatic read_trace();
    integer          fd;
    integer          n;
    integer          rd_num;
    reg [8*8-1:0]    tag;
    reg [8*200-1:0]  rest;
    word_t           a;
    word_t           b;
    for (int i = 0; i < MEM_WORDS; i++) begin
      imem[i] = '0;
      dmem[i] = '0;
    end
    fd = $fopen("test/core_trace.txt", "r");
    if (fd != 0) begin
      while ($fscanf(fd, "%s", tag) == 1) begin
        if (tag == "#") begin
          n = $fgets(rest, fd);
        end else if (tag == "I") begin
          n = $fscanf(fd, "%h", a);
          if (n != 1) begin
            error_count++;
            $display("an I line in the trace file has no instruction word");
          end else begin
            if (i_count < MEM_WORDS) begin
              imem[i_count] = a;
            end else begin
              error_count++;
              $display("program in the trace does not fit the instruction memory");
            end
            i_count++;
          end
        end else if (tag == "W") begin
          n = $fscanf(fd, "%d %h", rd_num, b);
          if (n != 2) begin
            error_count++;
            $display("a W line in the trace file lacks its register or value");
          end else begin
            exp_rd.push_back(reg_addr_t'(rd_num));
            exp_val.push_back(b);
          end
        end else if (tag == "M") begin
          n = $fscanf(fd, "%h %h", a, b);
          if (n != 2) begin
            error_count++;
            $display("an M line in the trace file lacks its address or data");
          end else begin
            exp_addr.push_back(a);
            exp_data.push_back(b);
          end
        end else begin
          error_count++;
          $display("unknown line tag in the trace file");
          n = $fgets(rest, fd);
        end
      end
      $fclose(fd);
      w_count = exp_rd.size();
      m_count = exp_addr.size();
      trace_loaded = 1'b1;
    end
  endtask

  // ==============================
  // compare tasks
  // ==============================
  task automatic expect_reset_pc(input word_t pc);
    if (pc !== RESET_PC) begin
      mismatch_count++;
      $display("error at %0d ns: fetch address after reset %h, expected %h",
               $time, pc, RESET_PC);
    end
  endtask

  task automatic check_reg_write(input reg_addr_t rd, input word_t data);
    if (rd !== exp_rd[w_seen] || data !== exp_val[w_seen]) begin
      mismatch_count++;
      $display("error at %0d ns: write %0d gave x%0d = %h, expected x%0d = %h",
               $time, w_seen, rd, data, exp_rd[w_seen], exp_val[w_seen]);
    end
    w_seen++;
  endtask

  task automatic check_store(input word_t addr, input word_t data);
    if (addr !== exp_addr[m_seen] || data !== exp_data[m_seen]) begin
      mismatch_count++;
      $display("error at %0d ns: store %0d gave [%h] = %h, expected [%h] = %h",
               $time, m_seen, addr, data, exp_addr[m_seen], exp_data[m_seen]);
    end
    m_seen++;
  endtask

  // sample on the falling edge where outputs are settled
  always @(negedge clk) begin
    if (arst_n) begin
      if (cycle == 0) begin
        expect_reset_pc(imem_addr);
      end
      if (wb_we !== 1'b0) begin
        if (cycle < 4) begin
          error_count++;
          $display("register write at %0d ns, before any instruction reached writeback",
                   $time);
        end else if (w_seen >= w_count) begin
          error_count++;
          $display("register write to x%0d at %0d ns after the last expected write",
                   wb_rd, $time);
        end else begin
          check_reg_write(wb_rd, wb_data);
        end
      end
      if (dmem_we !== 1'b0) begin
        if (cycle < 3) begin
          error_count++;
          $display("store at %0d ns, before any instruction reached memory", $time);
        end else if (m_seen >= m_count) begin
          error_count++;
          $display("store to %h at %0d ns after the last expected store", dmem_addr, $time);
        end else begin
          check_store(dmem_addr, dmem_wdata);
        end
      end
      cycle++;
    end
  end

  // ==============================
  // watchdog and end of run
  // ==============================
  initial begin
    wait (trace_loaded);
    repeat ((i_count + w_count) * 8 + 100) @(posedge clk);
    $display("timeout: the program did not finish, %0d of %0d writes and %0d of %0d stores seen",
             w_seen, w_count, m_seen, m_count);
    $display("errors: %0d, mismatches: %0d", error_count, mismatch_count);
    $display("CHECKS FAILED");
    $finish;
  end

  initial begin
    dmem_rdata = '0;
    read_trace();
    if (!trace_loaded) begin
      $display("could not open the trace file test/core_trace.txt");
      $display("CHECKS FAILED");
      $finish;
    end else begin
      wait (w_seen == w_count && m_seen == m_count);
      // stray writes from the final loop still show up here
      repeat (8) @(posedge clk);
      $display("errors: %0d, mismatches: %0d", error_count, mismatch_count);
      if (error_count == 0 && mismatch_count == 0) begin
        $display("ALL CHECKS PASSED");
      end else begin
        $display("CHECKS FAILED");
      end
      $finish;
    end
  end

endmodule

// ==== test/core_trace.txt ====
# I <instruction word, hex> | W <rd, decimal> <value, hex> | M <address, hex> <data, hex>
# W and M lines give the register writes and stores in program order
I 00500093  # 00 addi x1, x0, 5
W 1 00000005
I ffd00113  # 04 addi x2, x0, -3
W 2 fffffffd
I 002081b3  # 08 add x3, x1, x2
W 3 00000002
I 40208233  # 0c sub x4, x1, x2
W 4 00000008
I 001122b3  # 10 slt x5, x2, x1
W 5 00000001
I 00113333  # 14 sltu x6, x2, x1
W 6 00000000
I 0041c3b3  # 18 xor x7, x3, x4
W 7 0000000a
I 0053e433  # 1c or x8, x7, x5
W 8 0000000b
I 002474b3  # 20 and x9, x8, x2
W 9 00000009
I 00309533  # 24 sll x10, x1, x3
W 10 00000014
I 40115593  # 28 srai x11, x2, 1
W 11 fffffffe
I 01c15613  # 2c srli x12, x2, 28
W 12 0000000f
I 123456b7  # 30 lui x13, 0x12345
W 13 12345000
I 00001717  # 34 auipc x14, 1
W 14 00001034
I 00d02823  # 38 sw x13, 16(x0)
M 00000010 12345000
I 01002783  # 3c lw x15, 16(x0)
W 15 12345000
I 00178813  # 40 addi x16, x15, 1 right after the load
W 16 12345001
I 00708013  # 44 addi x0, x1, 7 has no write
I 001008b3  # 48 add x17, x0, x1
W 17 00000005
I 00189463  # 4c bne x17, x1, +8 not taken
I 00308463  # 50 beq x1, x3, +8 not taken
I 00309663  # 54 bne x1, x3, +12 taken
I 06300913  # 58 addi x18, x0, 99 wrong path
I 06200993  # 5c addi x19, x0, 98 wrong path
I 00188463  # 60 beq x17, x1, +8 taken
I 06100913  # 64 addi x18, x0, 97 wrong path
I 00c00a6f  # 68 jal x20, +12
W 20 0000006c
I 00100a93  # 6c addi x21, x0, 1 wrong path
I 00200b13  # 70 addi x22, x0, 2 wrong path
I 08000b93  # 74 addi x23, x0, 0x80
W 23 00000080
I 004b8c67  # 78 jalr x24, 4(x23)
W 24 0000007c
I 00300c93  # 7c addi x25, x0, 3 wrong path
I 00400d13  # 80 addi x26, x0, 4 wrong path
I 01802a23  # 84 sw x24, 20(x0)
M 00000014 0000007c
I 01402e83  # 88 lw x29, 20(x0)
W 29 0000007c
I 0000006f  # 8c jal x0, 0 final loop

// ==== list.f ====
design/rv_isa_pkg.sv
design/rv_core_pkg.sv
design/fetch_stage.sv
design/reg_file.sv
design/decode_stage.sv
design/hazard_unit.sv
design/execute_stage.sv
design/mem_wb_stage.sv
design/core_top.sv
test/core_tb.sv
